/* common/motion_macros.svh */
// Build-time sizes and version bytes of the motion core, included by the package, RTL and testbench
`ifndef MOTION_MACROS_SVH
`define MOTION_MACROS_SVH

// Axis count, sets all per-axis vector widths
`define NUM_MOTORS 2

// Host word and datapath widths
`define WORD_BITS 64
`define DDA_BITS 32
`define DURATION_BITS 32
`define COUNT_BITS 32

// Move buffer depth, keep a power of two
`define BUFFER_SIZE 2

// Tick divider
`define DIVISOR_BITS 8
`define DEFAULT_DIVISOR 4

// Version status word bytes
`define VERSION_MAJOR 1
`define VERSION_MINOR 2
`define VERSION_PATCH 3
`define VERSION_DEVEL 0

`endif

/* common/motion_pkg.sv */
// Opcodes, FSM states and register map of the motion core, imported by the RTL modules
`include "motion_macros.svh"

package motion_pkg;

  // Top byte of a header word
  typedef enum logic [7:0] {
    CMD_NONE             = 8'h00,
    CMD_COORDINATED_STEP = 8'h01,
    CMD_STATUS_REG       = 8'hF1,
    CMD_CONFIG_REG       = 8'hF2
  } cmd_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LOAD,
    SEQ_RUN
  } seq_state_e;

  localparam int SLOT_BITS = $clog2(`BUFFER_SIZE);

  // Status map, read only
  localparam int STATUS_VERSION          = 0;
  localparam int STATUS_CHANNEL_INFO     = 1;
  localparam int STATUS_STEP_COUNT_START = 2;
  localparam int STATUS_REG_COUNT        = STATUS_STEP_COUNT_START + `NUM_MOTORS;

  // Config map, read/write
  localparam int CONFIG_ENABLE    = 0;
  localparam int CONFIG_BRAKE     = 1;
  localparam int CONFIG_CLOCKS    = 2;
  localparam int CONFIG_REG_COUNT = CONFIG_CLOCKS + 1;

  localparam int MOVE_WORDS = 2 + 2 * `NUM_MOTORS; // Header, duration, two words per axis

endpackage

/* dv/motion_tb.sv */
// Table-driven testbench for motion_top with a host word model and a DDA reference model
`timescale 1ns/1ps
`include "motion_macros.svh"

module motion_tb import motion_pkg::*;;

  localparam int NUM_ROWS = 12;
  localparam int RESET_CYCLES = 10;
  localparam int WORD_CYCLES_MAX = 10; // Longest rise, hold and gap of one word
  localparam int KIND_REPLY = 0;       // Check the reply to one word
  localparam int KIND_PINS = 1;        // Check brake and enable outputs
  localparam int KIND_QUEUE = 2;       // Move left running under the next row
  localparam int KIND_MOVE = 3;        // Move checked against the DDA model

  logic                   CLK;
  logic                   resetn;
  logic [`WORD_BITS-1:0]  word_data;
  logic                   word_received;
  logic [`WORD_BITS-1:0]  word_send_data;
  logic [`NUM_MOTORS-1:0] step;
  logic [`NUM_MOTORS-1:0] dir;
  logic [`NUM_MOTORS-1:0] enable;
  logic [`NUM_MOTORS-1:0] brake;
  logic                   buffer_dtr;
  logic                   move_done;

  // Stimulus table
  string       test_name     [NUM_ROWS];
  int          test_kind     [NUM_ROWS];
  int          test_len      [NUM_ROWS];
  int          test_check_at [NUM_ROWS];
  logic [63:0] test_expect   [NUM_ROWS];
  logic [63:0] test_words    [NUM_ROWS][6];

  int row_count = 0;
  int row_errors = 0;
  int fail_count = 0;
  int timeout_cycles = 0;
  int rise_cycle = 0;
  int current_divisor = `DEFAULT_DIVISOR;
  int pending_moves = 0;
  int done_target = 0;
  int last_move_ticks = 0;
  int edge_base [`NUM_MOTORS] = '{default: 0};
  int model_pulses [`NUM_MOTORS] = '{default: 0};
  logic [`COUNT_BITS-1:0] model_count [`NUM_MOTORS] = '{default: '0}; // Expected positions

  // Monitor state
  int cycle_count = 0;
  int done_count = 0;
  int done_cycle = 0;
  int step_edges [`NUM_MOTORS] = '{default: 0};
  logic [`NUM_MOTORS-1:0] step_prev = '0;
  logic [`NUM_MOTORS-1:0] done_dir = '0; // dir seen on the last move_done

  motion_top i_motion_top (
    .CLK            (CLK),
    .resetn         (resetn),
    .word_data      (word_data),
    .word_received  (word_received),
    .word_send_data (word_send_data),
    .step           (step),
    .dir            (dir),
    .enable         (enable),
    .brake          (brake),
    .buffer_dtr     (buffer_dtr),
    .move_done      (move_done)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    step_prev <= step;
    if (move_done) begin
      done_count <= done_count + 1;
      done_cycle <= cycle_count;
      done_dir <= dir;
    end
    for (int a = 0; a < `NUM_MOTORS; a++) begin
      if (step[a] && !step_prev[a]) step_edges[a] <= step_edges[a] + 1;
    end
  end

  function automatic logic [63:0] make_header(input logic [7:0] opcode, input logic [7:0] low);
    return {opcode, 48'd0, low};
  endfunction

  // Config write to the clocks register
  function automatic bit clocks_write(input int i);
    return test_words[i][0][63:56] == CMD_CONFIG_REG && test_len[i] == 2 &&
           test_words[i][0][7:0] == 8'(CONFIG_CLOCKS);
  endfunction

  task automatic add_row(input string name, input int kind, input int check_at,
                         input logic [63:0] expected, input int len,
                         input logic [63:0] w0, input logic [63:0] w1, input logic [63:0] w2,
                         input logic [63:0] w3, input logic [63:0] w4, input logic [63:0] w5);
    test_name[row_count] = name;
    test_kind[row_count] = kind;
    test_check_at[row_count] = check_at;
    test_expect[row_count] = expected;
    test_len[row_count] = len;
    test_words[row_count] = '{w0, w1, w2, w3, w4, w5};
    row_count++;
  endtask

  task automatic fill_table();
    add_row("status_version", KIND_REPLY, 0, 64'h0000_0000_0001_0203, 1,
            make_header(CMD_STATUS_REG, 8'(STATUS_VERSION)), 0, 0, 0, 0, 0);
    add_row("status_channel_info", KIND_REPLY, 0, 64'h0000_0000_0020_0002, 1,
            make_header(CMD_STATUS_REG, 8'(STATUS_CHANNEL_INFO)), 0, 0, 0, 0, 0);
    add_row("unknown_header", KIND_REPLY, 0, 64'h0, 1, make_header(8'h55, 8'h01), 0, 0, 0, 0, 0);
    add_row("config_enable_write", KIND_PINS, 0, 64'b0011, 2,
            make_header(CMD_CONFIG_REG, 8'(CONFIG_ENABLE)), 3, 0, 0, 0, 0);
    add_row("config_enable_read", KIND_REPLY, 0, 64'h3, 2,
            make_header(CMD_CONFIG_REG, 8'(CONFIG_ENABLE)), 3, 0, 0, 0, 0);
    add_row("config_brake_write", KIND_PINS, 0, 64'b1011, 2,
            make_header(CMD_CONFIG_REG, 8'(CONFIG_BRAKE)), 2, 0, 0, 0, 0);
    add_row("constant_rate_move", KIND_MOVE, 0, 64'hFFFF_FFFB_0000_000A, 6,
            make_header(CMD_COORDINATED_STEP, 8'b10), 20, 64'h8000_0000, 0, 64'h4000_0000, 0);
    add_row("accel_move", KIND_MOVE, 0, 64'h0, 6, make_header(CMD_COORDINATED_STEP, 8'b01), 25,
            64'h0800_0000, 64'h0100_0000, 64'h1000_0000, 64'h0080_0000);
    add_row("config_clocks_write", KIND_REPLY, 0, 64'h4, 2,
            make_header(CMD_CONFIG_REG, 8'(CONFIG_CLOCKS)), 2, 0, 0, 0, 0);
    add_row("divided_move", KIND_MOVE, 0, 64'h0, 6, make_header(CMD_COORDINATED_STEP, 8'b00), 30,
            64'h6000_0000, 0, 64'h2000_0000, 64'h0020_0000);
    add_row("queued_move_a", KIND_QUEUE, 0, 64'h0, 6, make_header(CMD_COORDINATED_STEP, 8'b00),
            60, 64'h4000_0000, 0, 64'h3000_0000, 0);
    add_row("queued_move_b", KIND_MOVE, 0, 64'h0, 6, make_header(CMD_COORDINATED_STEP, 8'b11),
            16, 64'hC000_0000, 0, 64'h9000_0000, 64'h0100_0000);
  endtask

  // Sum of word cycles and move lengths, doubled
  function automatic int timeout_budget();
    int total;
    int divisor;
    total = RESET_CYCLES + 4;
    divisor = `DEFAULT_DIVISOR;
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (clocks_write(i)) divisor = int'(test_words[i][1][7:0]);
      total += (test_len[i] + `NUM_MOTORS) * WORD_CYCLES_MAX;
      if (test_kind[i] >= KIND_QUEUE) total += (int'(test_words[i][1][31:0]) + 1) * divisor + 16;
    end
    return 2 * total;
  endfunction

  task automatic report_mismatch(input string name, input string what,
                                 input logic [63:0] expected, input logic [63:0] actual);
    $display("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h", name, what, expected, actual);
    row_errors++;
  endtask

  task automatic report_failure(input string name, input string what);
    $display("Error in %s: %s", name, what);
    row_errors++;
  endtask

  // One host word under the strobe rule, reply taken 3 cycles after the rise
  task automatic send_word(input logic [63:0] word, output logic [63:0] reply);
    @(posedge CLK);
    word_data <= word;
    word_received <= 1'b1;
    rise_cycle = cycle_count;
    repeat (3) @(posedge CLK);
    reply = word_send_data;
    repeat ($urandom % 3) @(posedge CLK);
    word_received <= 1'b0;
    repeat (2 + $urandom % 3) @(posedge CLK);
  endtask

  // Reference DDA, carry of an unsigned add gives a step
  task automatic apply_model(input int i);
    logic [`DDA_BITS:0]   sum;
    logic [`DDA_BITS-1:0] acc;
    logic [`DDA_BITS-1:0] rate;
    last_move_ticks = (test_words[i][1][31:0] == 0) ? 1 : int'(test_words[i][1][31:0]);
    for (int a = 0; a < `NUM_MOTORS; a++) begin
      acc = '0;
      rate = test_words[i][2 + 2*a][`DDA_BITS-1:0];
      for (int t = 0; t < last_move_ticks; t++) begin
        sum = {1'b0, acc} + {1'b0, rate};
        acc = sum[`DDA_BITS-1:0];
        rate = rate + test_words[i][3 + 2*a][`DDA_BITS-1:0];
        if (sum[`DDA_BITS]) begin
          model_pulses[a]++;
          model_count[a] = test_words[i][0][a] ? model_count[a] - 1 : model_count[a] + 1;
        end
      end
    end
  endtask

  task automatic check_moves(input int i);
    logic [63:0] reply;
    int span;
    if (pending_moves > 1) begin
      if (buffer_dtr !== 1'b0) report_failure(test_name[i], "buffer_dtr high with both slots full");
      while (done_count < done_target - 1) @(posedge CLK);
      repeat (3) @(posedge CLK);
      if (buffer_dtr !== 1'b1) report_failure(test_name[i], "buffer_dtr low after first move_done");
    end
    while (done_count < done_target) @(posedge CLK);
    if (pending_moves == 1) begin
      span = done_cycle - rise_cycle; // A few cycles of load latency on top of the ticks
      if (span < last_move_ticks * current_divisor || span > last_move_ticks * current_divisor + 8)
        report_mismatch(test_name[i], "move cycles", last_move_ticks * current_divisor, span);
    end
    repeat (4) @(posedge CLK);
    if (done_count != done_target)
      report_mismatch(test_name[i], "move_done pulses", done_target, done_count);
    if (done_dir !== test_words[i][0][`NUM_MOTORS-1:0])
      report_mismatch(test_name[i], "dir at move_done", test_words[i][0][`NUM_MOTORS-1:0],
                      done_dir);
    for (int a = 0; a < `NUM_MOTORS; a++) begin
      send_word(make_header(CMD_STATUS_REG, 8'(STATUS_STEP_COUNT_START + a)), reply);
      if (reply !== {32'd0, model_count[a]})
        report_mismatch(test_name[i], $sformatf("axis %0d count", a), model_count[a], reply);
      if (test_expect[i] != 0 && reply[31:0] !== test_expect[i][32*a +: 32])
        report_mismatch(test_name[i], $sformatf("axis %0d table count", a),
                        test_expect[i][32*a +: 32], reply);
      if (step_edges[a] - edge_base[a] != model_pulses[a])
        report_mismatch(test_name[i], $sformatf("axis %0d step pulses", a), model_pulses[a],
                        step_edges[a] - edge_base[a]);
    end
    pending_moves = 0;
  endtask

  task automatic run_row(input int i);
    logic [63:0] reply;
    row_errors = 0;
    if (test_kind[i] >= KIND_QUEUE) begin
      while (!buffer_dtr) @(posedge CLK); // Wait for a free slot
      if (pending_moves == 0) begin
        for (int a = 0; a < `NUM_MOTORS; a++) begin
          edge_base[a] = step_edges[a];
          model_pulses[a] = 0;
        end
      end
    end
    for (int w = 0; w < test_len[i]; w++) begin
      send_word(test_words[i][w], reply);
      if (test_kind[i] == KIND_REPLY && w == test_check_at[i] && reply !== test_expect[i])
        report_mismatch(test_name[i], "reply", test_expect[i], reply);
    end
    if (test_kind[i] == KIND_PINS && {brake, enable} !== test_expect[i][3:0])
      report_mismatch(test_name[i], "brake and enable", test_expect[i][3:0], {brake, enable});
    if (clocks_write(i)) current_divisor = int'(test_words[i][1][7:0]);
    if (test_kind[i] >= KIND_QUEUE) begin
      apply_model(i);
      pending_moves++;
      done_target++;
    end
    if (test_kind[i] == KIND_MOVE) check_moves(i);
    if (row_errors != 0) fail_count++;
    $display("%s %s", (row_errors == 0) ? "PASS" : "FAIL", test_name[i]);
  endtask

  initial begin
    int seed;
    seed = $urandom(63);
    resetn = 1'b1;
    word_data = '0;
    word_received = 1'b0;
    fill_table();
    timeout_cycles = timeout_budget();
    repeat (RESET_CYCLES) @(posedge CLK);
    resetn <= 1'b0;
    repeat (2) @(posedge CLK);
    for (int i = 0; i < NUM_ROWS; i++) run_row(i);
    $display("Tests run %0d, passed %0d, failed %0d", NUM_ROWS, NUM_ROWS - fail_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (timeout_cycles > 0);
    repeat (timeout_cycles) @(posedge CLK);
    $display("Timeout after %0d cycles, the run did not finish", timeout_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* hw/command_decoder/command_decoder.sv */
// Host word decoder: parses commands, fills the move buffer and serves status and config registers
`timescale 1ns/1ps
`include "motion_macros.svh"

module command_decoder import motion_pkg::*; (
  input  logic                               CLK,
  input  logic                               resetn,
  input  logic [`WORD_BITS-1:0]              word_data,
  input  logic                               word_received,
  input  logic [SLOT_BITS-1:0]               slot_index,
  input  logic                               slot_release,
  input  logic [`NUM_MOTORS*`COUNT_BITS-1:0] step_counts,
  output logic [`WORD_BITS-1:0]              word_send_data,
  output logic [`BUFFER_SIZE-1:0]            slot_ready,
  output logic [`DURATION_BITS-1:0]          duration,
  output logic [`NUM_MOTORS-1:0]             dir_mask,
  output logic [`NUM_MOTORS*`DDA_BITS-1:0]   increments,
  output logic [`NUM_MOTORS*`DDA_BITS-1:0]   increment_increments,
  output logic [`DIVISOR_BITS-1:0]           tick_divisor,
  output logic [`NUM_MOTORS-1:0]             enable,
  output logic [`NUM_MOTORS-1:0]             brake,
  output logic                               buffer_dtr
);

  localparam int CONFIG_BITS = 32;

  logic                  word_received_d;
  logic                  word_rise;      // Edge seen one cycle ago
  logic [`WORD_BITS-1:0] data_q;
  cmd_e                  opcode;
  cmd_e                  message_header; // CMD_NONE when no message is open
  logic [7:0]            word_count;
  logic [7:0]            config_addr;
  logic [SLOT_BITS-1:0]  write_index;
  logic [`WORD_BITS-1:0] status_word;
  logic [CONFIG_BITS-1:0] config_word;

  // Move buffer
  logic [`NUM_MOTORS-1:0]    dir_slot      [`BUFFER_SIZE];
  logic [`DURATION_BITS-1:0] duration_slot [`BUFFER_SIZE];
  logic [`DDA_BITS-1:0]      inc_slot      [`BUFFER_SIZE][`NUM_MOTORS];
  logic [`DDA_BITS-1:0]      inc_inc_slot  [`BUFFER_SIZE][`NUM_MOTORS];

  logic [CONFIG_BITS-1:0] config_regs [CONFIG_REG_COUNT];
  logic [`WORD_BITS-1:0]  status_regs [STATUS_REG_COUNT];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_d <= 1'b0;
      word_rise <= 1'b0;
    end else begin
      word_received_d <= word_received;
      word_rise <= word_received & ~word_received_d;
    end
  end

  always_ff @(posedge CLK) begin
    if (word_received & ~word_received_d) data_q <= word_data; // Capture at the edge
  end

  assign opcode = cmd_e'(data_q[`WORD_BITS-1 -: 8]);

  assign status_regs[STATUS_VERSION] = {{(`WORD_BITS-32){1'b0}}, 8'(`VERSION_DEVEL),
                                        8'(`VERSION_MAJOR), 8'(`VERSION_MINOR),
                                        8'(`VERSION_PATCH)};
  assign status_regs[STATUS_CHANNEL_INFO] = {{(`WORD_BITS-32){1'b0}}, 8'd0,
                                             8'(`COUNT_BITS), 8'd0, 8'(`NUM_MOTORS)};

  for (genvar a = 0; a < `NUM_MOTORS; a++) begin : g_slot_out
    assign status_regs[STATUS_STEP_COUNT_START + a] =
      {{(`WORD_BITS-`COUNT_BITS){1'b0}}, step_counts[a*`COUNT_BITS +: `COUNT_BITS]};
    assign increments[a*`DDA_BITS +: `DDA_BITS] = inc_slot[slot_index][a];
    assign increment_increments[a*`DDA_BITS +: `DDA_BITS] = inc_inc_slot[slot_index][a];
  end

  // Register reads, out-of-range addresses give zero
  always_comb begin
    status_word = '0;
    config_word = '0;
    for (int i = 0; i < STATUS_REG_COUNT; i++) begin
      if (data_q[7:0] == 8'(i)) status_word = status_regs[i];
    end
    for (int i = 0; i < CONFIG_REG_COUNT; i++) begin
      if (data_q[7:0] == 8'(i)) config_word = config_regs[i];
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_send_data <= '0;
      message_header <= CMD_NONE;
      word_count <= '0;
      config_addr <= '0;
      write_index <= '0;
      slot_ready <= '0;
      config_regs[CONFIG_ENABLE] <= '0;
      config_regs[CONFIG_BRAKE] <= '0;
      config_regs[CONFIG_CLOCKS] <= CONFIG_BITS'(`DEFAULT_DIVISOR);
    end else begin
      if (slot_release) slot_ready[slot_index] <= 1'b0; // Sequencer done with the slot
      if (word_rise) begin
        word_send_data <= '0;
        if (message_header == CMD_NONE) begin
          word_count <= 8'd1;
          case (opcode)
            CMD_COORDINATED_STEP: begin
              message_header <= CMD_COORDINATED_STEP;
              dir_slot[write_index] <= data_q[`NUM_MOTORS-1:0];
            end
            CMD_STATUS_REG: word_send_data <= status_word;
            CMD_CONFIG_REG: begin
              message_header <= CMD_CONFIG_REG;
              config_addr <= data_q[7:0];
              word_send_data <= {{(`WORD_BITS-CONFIG_BITS){1'b0}}, config_word};
            end
            default: ; // Unknown header, reply stays zero
          endcase
        end else if (message_header == CMD_CONFIG_REG) begin
          for (int i = 0; i < CONFIG_REG_COUNT; i++) begin
            if (config_addr == 8'(i)) config_regs[i] <= data_q[CONFIG_BITS-1:0];
          end
          message_header <= CMD_NONE;
          word_count <= '0;
        end else begin
          word_count <= word_count + 8'd1;
          if (word_count == 8'd1) duration_slot[write_index] <= data_q[`DURATION_BITS-1:0];
          for (int a = 0; a < `NUM_MOTORS; a++) begin
            if (word_count == 8'(2 + 2*a)) inc_slot[write_index][a] <= data_q[`DDA_BITS-1:0];
            if (word_count == 8'(3 + 2*a)) inc_inc_slot[write_index][a] <= data_q[`DDA_BITS-1:0];
          end
          if (word_count == 8'(MOVE_WORDS - 1)) begin
            // Last axis word, hand the slot over
            slot_ready[write_index] <= 1'b1;
            write_index <= write_index + 1'b1;
            message_header <= CMD_NONE;
            word_count <= '0;
          end
        end
      end
    end
  end

  assign duration = duration_slot[slot_index];
  assign dir_mask = dir_slot[slot_index];
  assign tick_divisor = config_regs[CONFIG_CLOCKS][`DIVISOR_BITS-1:0];
  assign enable = config_regs[CONFIG_ENABLE][`NUM_MOTORS-1:0];
  assign brake = config_regs[CONFIG_BRAKE][`NUM_MOTORS-1:0];
  assign buffer_dtr = ~slot_ready[write_index];

  a_write_index_range: assert property (@(posedge CLK) disable iff (resetn)
    int'(write_index) < `BUFFER_SIZE);

  // Host must wait for buffer_dtr before opening a move
  a_no_overwrite: assert property (@(posedge CLK) disable iff (resetn)
    word_rise && message_header == CMD_NONE && opcode == CMD_COORDINATED_STEP
    |-> !slot_ready[write_index]);

  a_word_count_bound: assert property (@(posedge CLK) disable iff (resetn)
    int'(word_count) <= MOVE_WORDS);

endmodule

/* hw/dda/dda_axis.sv */
// One axis of DDA step generation with a signed step counter, instanced per motor
`timescale 1ns/1ps
`include "motion_macros.svh"

module dda_axis (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   tick,
  input  logic                   load_move,
  input  logic [`DDA_BITS-1:0]   increment,
  input  logic [`DDA_BITS-1:0]   increment_increment,
  input  logic                   dir,
  output logic                   step,
  output logic [`COUNT_BITS-1:0] step_count  // Two's complement position
);

  logic [`DDA_BITS-1:0] accumulator;
  logic [`DDA_BITS-1:0] rate;
  logic [`DDA_BITS:0]   sum;

  assign sum = {1'b0, accumulator} + {1'b0, rate}; // Top bit is the carry

  always_ff @(posedge CLK) begin
    if (resetn) begin
      accumulator <= '0;
      step <= 1'b0;
      step_count <= '0;
    end else begin
      step <= 1'b0;
      if (load_move) begin
        accumulator <= '0;
      end else if (tick) begin
        accumulator <= sum[`DDA_BITS-1:0];
        step <= sum[`DDA_BITS];
        if (sum[`DDA_BITS]) begin
          // Set dir bit counts down
          step_count <= dir ? step_count - 1'b1 : step_count + 1'b1;
        end
      end
    end
  end

  // Rate ramps after each tick
  always_ff @(posedge CLK) begin
    if (load_move) begin
      rate <= increment;
    end else if (tick) begin
      rate <= rate + increment_increment;
    end
  end

  a_step_after_tick: assert property (@(posedge CLK) disable iff (resetn)
    step |-> $past(tick));

endmodule

/* hw/dda/dda_sequencer.sv */
// Move sequencer: divides the clock into DDA ticks and steps through the buffered move slots
`timescale 1ns/1ps
`include "motion_macros.svh"

module dda_sequencer import motion_pkg::*; (
  input  logic                      CLK,
  input  logic                      resetn,
  input  logic [`BUFFER_SIZE-1:0]   slot_ready,
  input  logic [`DURATION_BITS-1:0] duration,
  input  logic [`DIVISOR_BITS-1:0]  tick_divisor,
  output logic [SLOT_BITS-1:0]      slot_index,
  output logic                      slot_release,
  output logic                      load_move,
  output logic                      tick,
  output logic                      move_done
);

  seq_state_e                state;
  logic [`DIVISOR_BITS-1:0]  div_count;
  logic [`DURATION_BITS-1:0] tick_count;  // Ticks already issued this move
  logic                      div_wrap;
  logic                      last_tick;

  // Divisor of 0 or 1 ticks every cycle
  assign div_wrap = ({1'b0, div_count} + 1'b1) >= {1'b0, tick_divisor};

  // Zero duration still ends on the first tick
  assign last_tick = tick && (({1'b0, tick_count} + 1'b1) >= {1'b0, duration});

  assign load_move = (state == SEQ_LOAD);
  assign move_done = (state == SEQ_RUN) && last_tick;
  assign slot_release = move_done;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state <= SEQ_IDLE;
      slot_index <= '0;
      div_count <= '0;
      tick_count <= '0;
      tick <= 1'b0;
    end else begin
      tick <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (slot_ready[slot_index]) state <= SEQ_LOAD;
        end
        SEQ_LOAD: begin
          div_count <= '0;
          tick_count <= '0;
          state <= SEQ_RUN;
        end
        SEQ_RUN: begin
          if (move_done) begin
            slot_index <= slot_index + 1'b1; // Next slot in ring order
            state <= SEQ_IDLE;
          end else begin
            if (tick) tick_count <= tick_count + 1'b1;
            if (div_wrap) begin
              div_count <= '0;
              tick <= 1'b1;
            end else begin
              div_count <= div_count + 1'b1;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // Axes must never see a tick on the load cycle
  a_tick_not_load: assert property (@(posedge CLK) disable iff (resetn)
    !(tick && load_move));

  a_done_in_run: assert property (@(posedge CLK) disable iff (resetn)
    move_done |-> state == SEQ_RUN ##1 state == SEQ_IDLE);

endmodule

/* hw/motion_top.sv */
// Motion core top: host command decoder feeding the move sequencer and the per-axis DDAs
`timescale 1ns/1ps
`include "motion_macros.svh"

module motion_top import motion_pkg::*; (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic [`WORD_BITS-1:0]  word_data,
  input  logic                   word_received,
  output logic [`WORD_BITS-1:0]  word_send_data,
  output logic [`NUM_MOTORS-1:0] step,
  output logic [`NUM_MOTORS-1:0] dir,
  output logic [`NUM_MOTORS-1:0] enable,
  output logic [`NUM_MOTORS-1:0] brake,
  output logic                   buffer_dtr,
  output logic                   move_done
);

  logic [SLOT_BITS-1:0]               slot_index;
  logic [`BUFFER_SIZE-1:0]            slot_ready;
  logic                               slot_release;
  logic                               load_move;
  logic                               tick;
  logic [`DURATION_BITS-1:0]          duration;
  logic [`DIVISOR_BITS-1:0]           tick_divisor;
  logic [`NUM_MOTORS*`DDA_BITS-1:0]   increments;
  logic [`NUM_MOTORS*`DDA_BITS-1:0]   increment_increments;
  logic [`NUM_MOTORS*`COUNT_BITS-1:0] step_counts;

  command_decoder i_command_decoder (
    .CLK                  (CLK),
    .resetn               (resetn),
    .word_data            (word_data),
    .word_received        (word_received),
    .slot_index           (slot_index),
    .slot_release         (slot_release),
    .step_counts          (step_counts),
    .word_send_data       (word_send_data),
    .slot_ready           (slot_ready),
    .duration             (duration),
    .dir_mask             (dir),          // Running slot's mask
    .increments           (increments),
    .increment_increments (increment_increments),
    .tick_divisor         (tick_divisor),
    .enable               (enable),
    .brake                (brake),
    .buffer_dtr           (buffer_dtr)
  );

  dda_sequencer i_dda_sequencer (
    .CLK          (CLK),
    .resetn       (resetn),
    .slot_ready   (slot_ready),
    .duration     (duration),
    .tick_divisor (tick_divisor),
    .slot_index   (slot_index),
    .slot_release (slot_release),
    .load_move    (load_move),
    .tick         (tick),
    .move_done    (move_done)
  );

  for (genvar a = 0; a < `NUM_MOTORS; a++) begin : g_axis
    dda_axis i_dda_axis (
      .CLK                 (CLK),
      .resetn              (resetn),
      .tick                (tick),
      .load_move           (load_move),
      .increment           (increments[a*`DDA_BITS +: `DDA_BITS]),
      .increment_increment (increment_increments[a*`DDA_BITS +: `DDA_BITS]),
      .dir                 (dir[a]),
      .step                (step[a]),
      .step_count          (step_counts[a*`COUNT_BITS +: `COUNT_BITS])
    );
  end

endmodule

/* project.f */
+incdir+common
common/motion_pkg.sv
hw/command_decoder/command_decoder.sv
hw/dda/dda_sequencer.sv
hw/dda/dda_axis.sv
hw/motion_top.sv
dv/motion_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the motion core testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module motion_tb \
  -Mdir build/obj_dir -o motion_tb

./build/obj_dir/motion_tb | tee build/sim.log

if grep -q "ALL TESTS PASSED" build/sim.log; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail"
  exit 1
fi
